/* include/nobl_fifo_defines.svh */
// NoBL FIFO build-time sizes for the data path, the SRAM and the output side
`ifndef NOBL_FIFO_DEFINES_SVH
`define NOBL_FIFO_DEFINES_SVH

// Width of one stored word as it sits in the SRAM
`define NOBL_DATA_W 18

// SRAM address width, which also sets the pointer and level width
// Six bits keep the full condition short enough to reach in simulation
`define NOBL_ADDR_W 6

// Entries in the read pacer's output buffer, a power of two
`define NOBL_OUTBUF_DEPTH 8

// Cycles from an accepted read request to the controller's valid strobe
`define NOBL_RD_LATENCY 4

`endif

/* design/nobl_fifo_pkg.sv */
// NoBL FIFO shared types for words, pointers, access requests and SRAM pins
`include "nobl_fifo_defines.svh"

package nobl_fifo_pkg;

	// One data word as stored in the SRAM
	typedef logic [`NOBL_DATA_W-1:0] nobl_word_t;

	// SRAM address and FIFO pointer
	typedef logic [`NOBL_ADDR_W-1:0] nobl_addr_t;

	// Count of words held in the SRAM
	// The all-ones value marks the buffer as full
	typedef logic [`NOBL_ADDR_W-1:0] nobl_level_t;

	// Kind of access carried through the controller pipeline
	typedef enum logic [1:0]
	{
		OP_IDLE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} nobl_op_e;

	// One access request from the pointer logic to the SRAM controller
	typedef struct packed
	{
		nobl_op_e   op;
		nobl_addr_t addr;
		nobl_word_t wdata;
	} nobl_req_t;

	// Everything the controller drives toward the SRAM
	// All control strobes are active low as on the device
	typedef struct packed
	{
		nobl_addr_t addr;
		logic       we_n;
		logic       cen_n;
		logic       ld_n;
		logic       oe_n;
		logic       ce1_n;
		logic       d_oe;
		nobl_word_t d_out;
	} nobl_pins_t;

endpackage

/* design/nobl_fifo.sv */
// NoBL FIFO pointer, level and flag logic that shares one SRAM port between writes and reads
`timescale 1ns/10ps

module nobl_fifo
	import nobl_fifo_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  nobl_word_t  in_data,
	input  logic        in_valid,
	output logic        in_ready,
	input  logic        read_strobe,
	output logic        read_taken,
	output nobl_level_t level,
	output nobl_req_t   req
);

	// Highest level the SRAM can hold
	localparam nobl_level_t LEVEL_MAX = '1;

	nobl_addr_t  wr_ptr;
	nobl_addr_t  rd_ptr;
	nobl_level_t level_next;
	logic        data_avail;
	logic        write;
	logic        read;
	logic        read_only;

	// Both flags are registered so a handshake here never waits on the SRAM side
	assign write = in_valid && in_ready;
	assign read = read_strobe && data_avail;

	// On a collision the write wins the port
	// The read strobe stays up and the read goes through next cycle
	assign read_only = read && !write;

	// The pacer spends a credit only when its read really reached the SRAM
	assign read_taken = read_only;

	// Level after this cycle's accesses
	// A collision adds a word and removes none
	always_comb
	begin
		level_next = level + nobl_level_t'(write) - nobl_level_t'(read_only);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
			in_ready <= 1'b1;
			data_avail <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr + nobl_addr_t'(write);
			rd_ptr <= rd_ptr + nobl_addr_t'(read_only);
			level <= level_next;
			// Look one cycle ahead so the last free word closes the input in time
			// A collision also closes it for one cycle to let the deferred read through
			in_ready <= (level_next != LEVEL_MAX) && !(read && write);
			// Look ahead the same way at the last stored word so no read runs dry
			data_avail <= (level_next != '0);
		end
	end

	// Request toward the controller, built in the cycle of the handshake
	always_comb
	begin
		req.wdata = in_data;
		if (write)
		begin
			req.op = OP_WRITE;
			req.addr = wr_ptr;
		end
		else if (read)
		begin
			req.op = OP_READ;
			req.addr = rd_ptr;
		end
		else
		begin
			// Idle cycles keep the read pointer on the bus to limit toggling
			req.op = OP_IDLE;
			req.addr = rd_ptr;
		end
	end

endmodule

/* design/nobl_if.sv */
// NoBL SRAM controller that pipelines accesses onto the ZBT pins and returns read data
`timescale 1ns/10ps
`include "nobl_fifo_defines.svh"

module nobl_if
	import nobl_fifo_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  nobl_req_t  req,
	output nobl_pins_t pins,
	input  nobl_word_t ram_d_in,
	output nobl_word_t rd_data,
	output logic       rd_valid
);

	localparam int LAT = `NOBL_RD_LATENCY;
	// Stage that sits in the cycle before the write data phase
	localparam int WR_STAGE = 1;
	// Stage whose cycle carries read data from the SRAM
	localparam int CAP_STAGE = LAT - 2;

	// Opcode of each access in flight
	// Stage 0 is the address phase on the pins
	nobl_op_e   op_q [LAT];
	nobl_word_t wd_q [2];
	nobl_addr_t addr_q;
	nobl_word_t d_out_q;
	logic       we_n_q;
	logic       cen_n_q;
	logic       ld_n_q;
	logic       oe_n_q;
	logic       ce1_n_q;
	logic       d_oe_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < LAT; i++)
			begin
				op_q[i] <= OP_IDLE;
			end
			we_n_q <= 1'b1;
			cen_n_q <= 1'b1;
			ld_n_q <= 1'b1;
			oe_n_q <= 1'b1;
			ce1_n_q <= 1'b1;
			d_oe_q <= 1'b0;
		end
		else
		begin
			op_q[0] <= req.op;
			for (int i = 1; i < LAT; i++)
			begin
				op_q[i] <= op_q[i-1];
			end
			// Without bursts every enabled cycle loads a fresh address
			cen_n_q <= (req.op == OP_IDLE);
			ld_n_q <= (req.op == OP_IDLE);
			we_n_q <= (req.op != OP_WRITE);
			ce1_n_q <= 1'b0;
			// The bus turns around only for the write data phase
			// The SRAM output is shut off in exactly those cycles
			d_oe_q <= (op_q[WR_STAGE] == OP_WRITE);
			oe_n_q <= (op_q[WR_STAGE] == OP_WRITE);
		end
	end

	// Address and write data travel down their own registers
	always_ff @(posedge clk)
	begin
		addr_q <= req.addr;
		wd_q[0] <= req.wdata;
		wd_q[1] <= wd_q[0];
		d_out_q <= wd_q[1];
		// Read data is sampled at the end of its data phase
		if (op_q[CAP_STAGE] == OP_READ)
		begin
			rd_data <= ram_d_in;
		end
	end

	// The strobe follows the capture by one stage
	assign rd_valid = (op_q[LAT-1] == OP_READ);

	assign pins = '{
		addr:  addr_q,
		we_n:  we_n_q,
		cen_n: cen_n_q,
		ld_n:  ld_n_q,
		oe_n:  oe_n_q,
		ce1_n: ce1_n_q,
		d_oe:  d_oe_q,
		d_out: d_out_q
	};

endmodule

/* design/nobl_read_pacer.sv */
// NoBL read pacer that issues reads against output buffer credits and feeds a valid/ready stream
`timescale 1ns/10ps
`include "nobl_fifo_defines.svh"

module nobl_read_pacer
	import nobl_fifo_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       read_taken,
	output logic       read_strobe,
	input  nobl_word_t rd_data,
	input  logic       rd_valid,
	output nobl_word_t out_data,
	output logic       out_valid,
	input  logic       out_ready
);

	localparam int DEPTH = `NOBL_OUTBUF_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	// Free slots plus slots reserved for reads still in the SRAM pipeline
	logic [CNT_W-1:0] credits;
	// Words sitting in the output buffer
	logic [CNT_W-1:0] count;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic             pop;
	nobl_word_t       obuf_mem [DEPTH];

	// Each issued read already owns a slot, so returned words always fit
	assign read_strobe = (credits != '0);

	assign out_valid = (count != '0);
	assign pop = out_valid && out_ready;

	// The head entry only moves on a pop so stalled data holds still
	assign out_data = obuf_mem[rd_idx];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			credits <= CNT_W'(DEPTH);
			count <= '0;
			wr_idx <= '0;
			rd_idx <= '0;
		end
		else
		begin
			// A slot is reserved at issue and freed when the word leaves
			credits <= credits - CNT_W'(read_taken) + CNT_W'(pop);
			count <= count + CNT_W'(rd_valid) - CNT_W'(pop);
			// Indices wrap by themselves since the depth is a power of two
			wr_idx <= wr_idx + IDX_W'(rd_valid);
			rd_idx <= rd_idx + IDX_W'(pop);
		end
	end

	// Returned words land in the slot after the last one written
	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			obuf_mem[wr_idx] <= rd_data;
		end
	end

endmodule

/* design/nobl_fifo_top.sv */
// NoBL FIFO top level joining pointer logic, SRAM controller and read pacer
`timescale 1ns/10ps

module nobl_fifo_top
	import nobl_fifo_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  nobl_word_t  in_data,
	input  logic        in_valid,
	output logic        in_ready,
	output nobl_word_t  out_data,
	output logic        out_valid,
	input  logic        out_ready,
	output nobl_level_t level,
	output nobl_pins_t  pins,
	input  nobl_word_t  ram_d_in
);

	nobl_req_t  req;
	logic       read_strobe;
	logic       read_taken;
	nobl_word_t rd_data;
	logic       rd_valid;

	// Write side and read side meet here on the single SRAM port
	nobl_fifo u_fifo
	(
		.clk         (clk),
		.rst         (rst),
		.in_data     (in_data),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.read_strobe (read_strobe),
		.read_taken  (read_taken),
		.level       (level),
		.req         (req)
	);

	// Turns each request into ZBT pin activity and collects read data
	nobl_if u_if
	(
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.pins     (pins),
		.ram_d_in (ram_d_in),
		.rd_data  (rd_data),
		.rd_valid (rd_valid)
	);

	// Keeps reads in step with room downstream
	nobl_read_pacer u_pacer
	(
		.clk         (clk),
		.rst         (rst),
		.read_taken  (read_taken),
		.read_strobe (read_strobe),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready)
	);

endmodule

/* verification/nobl_sram_model.sv */
// Behavioral ZBT SRAM with pipelined read and write data phases two cycles after the address
`timescale 1ns/10ps
`include "nobl_fifo_defines.svh"

module nobl_sram_model
	import nobl_fifo_pkg::*;
(
	input  logic       clk,
	input  nobl_pins_t pins,
	output nobl_word_t d_out
);

	localparam int WORDS = 1 << `NOBL_ADDR_W;

	nobl_word_t mem [WORDS];

	// Two pipeline stages between the address phase and the data phase
	logic       v1 = 1'b0;
	logic       w1 = 1'b0;
	logic       v2 = 1'b0;
	logic       w2 = 1'b0;
	nobl_addr_t a1;
	nobl_addr_t a2;

	// Every word starts with a pattern built from its full address
	initial
	begin
		for (int i = 0; i < WORDS; i++)
		begin
			mem[i] = nobl_word_t'({nobl_addr_t'(i), ~nobl_addr_t'(i), nobl_addr_t'(i)});
		end
	end

	always @(posedge clk)
	begin
		v1 <= !pins.cen_n && !pins.ce1_n && !pins.ld_n;
		w1 <= !pins.we_n;
		a1 <= pins.addr;
		v2 <= v1;
		w2 <= w1;
		a2 <= a1;
		// Write data is taken at the end of its data phase
		if (v2 && w2 && pins.d_oe)
		begin
			mem[a2] <= pins.d_out;
		end
	end

	// Read data sits on the bus during the data phase while outputs are enabled
	assign d_out = (v2 && !w2 && !pins.oe_n) ? mem[a2] : '0;

endmodule

/* verification/nobl_fifo_chk.sv */
// NoBL FIFO checker with concurrent assertions on flags, SRAM bus direction and pacer credits
`timescale 1ns/10ps
`include "nobl_fifo_defines.svh"

module nobl_fifo_chk
	import nobl_fifo_pkg::*;
(
	input logic                                      clk,
	input logic                                      rst,
	input logic                                      in_valid,
	input logic                                      in_ready,
	input nobl_word_t                                out_data,
	input logic                                      out_valid,
	input logic                                      out_ready,
	input nobl_pins_t                                pins,
	input logic                                      read_strobe,
	input nobl_level_t                               level,
	input logic [$clog2(`NOBL_OUTBUF_DEPTH+1)-1:0]   credits
);

	// Controller and SRAM never drive the data bus at once
	// The controller drives it only in the data phase two cycles after a write address
	a_bus_dir: assert property (@(posedge clk) disable iff (rst)
		!(pins.d_oe && !pins.oe_n) && (pins.d_oe == $past(!pins.cen_n && !pins.we_n, 2)))
		else $error("SRAM data bus driven outside the write data phase");

	// A stalled output word holds still
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> $stable(out_data))
		else $error("out_data changed while stalled");

	// A collision closes the input for the following cycle
	a_collision: assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready && read_strobe && (level != '0) |=> !in_ready)
		else $error("in_ready high after a collision");

	a_credits: assert property (@(posedge clk) disable iff (rst)
		credits <= `NOBL_OUTBUF_DEPTH)
		else $error("pacer credits above the output buffer depth");

endmodule

bind nobl_fifo_top nobl_fifo_chk u_chk
(
	.clk         (clk),
	.rst         (rst),
	.in_valid    (in_valid),
	.in_ready    (in_ready),
	.out_data    (out_data),
	.out_valid   (out_valid),
	.out_ready   (out_ready),
	.pins        (pins),
	.read_strobe (read_strobe),
	.level       (level),
	.credits     (u_pacer.credits)
);

/* verification/nobl_fifo_tb.sv */
// NoBL FIFO testbench that runs file-driven tests against a reference queue
`timescale 1ns/10ps
`include "nobl_fifo_defines.svh"

module nobl_fifo_tb
	import nobl_fifo_pkg::*;
();

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	nobl_word_t  in_data = '0;
	logic        in_valid = 1'b0;
	logic        in_ready;
	nobl_word_t  out_data;
	logic        out_valid;
	logic        out_ready = 1'b0;
	nobl_level_t level;
	nobl_pins_t  pins;
	nobl_word_t  ram_d;

	integer      seed = 32'h9cdd_3dd6;
	nobl_word_t  ref_q [$];
	int          accepted = 0;
	int          errors = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	logic        in_taken = 1'b0;
	logic        stall_prev = 1'b0;
	logic        coll_prev = 1'b0;
	// Write address phases seen on the pins over the last two cycles
	logic [1:0]  wr_hist = 2'b00;
	nobl_word_t  held;
	string       cur_name = "reset";
	string       t_name [$];
	string       t_kind [$];
	int          t_words [$];
	int          t_off [$];
	int          t_prob [$];
	longint      wd_ns = 0;
	logic        loaded = 1'b0;
	logic        load_ok = 1'b0;

	nobl_fifo_top u_dut
	(
		.clk       (clk),
		.rst       (rst),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.level     (level),
		.pins      (pins),
		.ram_d_in  (ram_d)
	);

	nobl_sram_model u_sram
	(
		.clk   (clk),
		.pins  (pins),
		.d_out (ram_d)
	);

	always #20 clk = ~clk;

	task compare_word(input nobl_word_t expected, input nobl_word_t actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s word expected %h actual %h", cur_name, expected, actual);
			errors++;
		end
	endtask

	task compare_level(input nobl_level_t expected, input nobl_level_t actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s level expected %0d actual %0d", cur_name, expected, actual);
			errors++;
		end
	endtask

	task compare_count(input int expected, input int actual);
		if (expected != actual)
		begin
			$display("MISMATCH %s accepted words expected %0d actual %0d", cur_name, expected,
				actual);
			errors++;
		end
	endtask

	// True with the given percentage
	function automatic logic roll(input int prob);
		return int'($unsigned($random(seed)) % 32'd100) < prob;
	endfunction

	// Upstream keeps a word and its valid until the FIFO takes it
	task drive_input(input int prob, input int base, input int lim);
		if (in_valid && !in_taken)
		begin
			in_valid = 1'b1;
		end
		else if (accepted - base >= lim)
		begin
			in_valid = 1'b0;
		end
		else
		begin
			in_valid = roll(prob);
			in_data = nobl_word_t'($random(seed));
		end
	endtask

	task send_words(input int in_prob, input int rdy_prob, input int base, input int lim);
		logic done;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			drive_input(in_prob, base, lim);
			out_ready = roll(rdy_prob);
			done = (accepted - base >= lim) && !in_valid;
		end
	endtask

	// Stops the writer, lets every word out and checks that the FIFO ends empty
	task drain_all();
		@(negedge clk);
		in_valid = 1'b0;
		out_ready = 1'b1;
		while (ref_q.size() != 0)
		begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		if (out_valid)
		begin
			$display("%s: out_valid still high after every word came out", cur_name);
			errors++;
		end
		compare_level('0, level);
	endtask

	task load_tests();
		int    fd;
		int    n;
		int    w;
		int    o;
		int    p;
		string line;
		string nm;
		string kd;
		fd = $fopen("verification/nobl_fifo_input.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				// A failed read at the end of the file leaves no new line to parse
				if (n != 0)
				begin
					n = $sscanf(line, "%s %s %d %d %d", nm, kd, w, o, p);
					if (n == 5)
					begin
						t_name.push_back(nm);
						t_kind.push_back(kd);
						t_words.push_back(w);
						t_off.push_back(o);
						t_prob.push_back(p);
						wd_ns += longint'(w) * 40 * 40;
					end
				end
			end
			$fclose(fd);
			load_ok = (t_name.size() != 0);
		end
	endtask

	task run_test(input int i);
		int base;
		int low_run;
		int err0;
		cur_name = t_name[i];
		seed = 32'h9cdd_3dd6 + t_off[i];
		err0 = errors;
		base = accepted;
		if (t_kind[i] == "single")
		begin
			// One word in flight at a time
			for (int k = 0; k < t_words[i]; k++)
			begin
				send_words(100, 100, base, k + 1);
				while (ref_q.size() != 0)
				begin
					@(negedge clk);
				end
			end
			drain_all();
		end
		else if (t_kind[i] == "stream")
		begin
			send_words(t_prob[i], t_prob[i], base, t_words[i]);
			drain_all();
		end
		else if (t_kind[i] == "drain")
		begin
			send_words(t_prob[i], 0, base, t_words[i]);
			drain_all();
		end
		else if (t_kind[i] == "full")
		begin
			// Keep offering words with the output stalled until the input stays closed
			low_run = 0;
			while (low_run < 16)
			begin
				@(negedge clk);
				out_ready = 1'b0;
				drive_input(100, base, t_words[i] + 8);
				low_run = in_ready ? 0 : low_run + 1;
			end
			compare_count(t_words[i], accepted - base);
			compare_level(nobl_level_t'((1 << `NOBL_ADDR_W) - 1), level);
			drain_all();
		end
		else
		begin
			$display("%s: unknown test kind %s", cur_name, t_kind[i]);
			errors++;
		end
		if (errors == err0)
		begin
			$display("PASS %s, %0d words", cur_name, accepted - base);
			n_pass++;
		end
		else
		begin
			$display("FAIL %s, %0d errors", cur_name, errors - err0);
			n_fail++;
		end
	endtask

	// Scoreboard and protocol monitor, sampled at the rising edge
	always @(posedge clk)
	begin
		if (!rst)
		begin
			if (in_valid && in_ready)
			begin
				ref_q.push_back(in_data);
				accepted++;
			end
			if (out_valid && out_ready)
			begin
				if (ref_q.size() == 0)
				begin
					$display("%s: word %h came out with nothing expected", cur_name, out_data);
					errors++;
				end
				else
				begin
					compare_word(ref_q.pop_front(), out_data);
				end
			end
			if (stall_prev && out_valid)
			begin
				compare_word(held, out_data);
			end
			if (coll_prev && in_ready)
			begin
				$display("%s: in_ready stayed high after a write and read collided", cur_name);
				errors++;
			end
			if (pins.d_oe && !pins.oe_n)
			begin
				$display("%s: SRAM data bus driven from both sides", cur_name);
				errors++;
			end
			// The controller owns the bus only two cycles after a write address phase
			if (pins.d_oe !== wr_hist[1])
			begin
				$display("%s: SRAM write data phase out of step with its address", cur_name);
				errors++;
			end
			if (u_dut.u_pacer.credits > `NOBL_OUTBUF_DEPTH)
			begin
				$display("%s: pacer credits went above the buffer depth", cur_name);
				errors++;
			end
		end
		in_taken <= in_valid && in_ready && !rst;
		stall_prev <= out_valid && !out_ready && !rst;
		held <= out_data;
		coll_prev <= in_valid && in_ready && u_dut.u_fifo.read_strobe
			&& (level != '0) && !rst;
		wr_hist <= {wr_hist[0], !pins.cen_n && !pins.we_n && !rst};
	end

	initial
	begin
		wait (loaded);
		#(wd_ns);
		$display("Watchdog expired after %0d ns with tests still running", wd_ns);
		$display("test failed");
		$finish;
	end

	initial
	begin
		load_tests();
		if (!load_ok)
		begin
			$display("Could not read any test from the data file");
			$display("test failed");
			$finish;
		end
		else
		begin
			loaded = 1'b1;
			repeat (3) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			for (int i = 0; i < t_name.size(); i++)
			begin
				run_test(i);
			end
			$display("Summary: %0d tests passing, %0d tests failing", n_pass, n_fail);
			if (n_fail == 0 && errors == 0)
			begin
				$display("test passed");
			end
			else
			begin
				$display("test failed");
			end
			$finish;
		end
	end

endmodule

/* verification/nobl_fifo_input.txt */
# Columns: name kind words seed_offset ready_percent
# Kinds: single stream full drain (ready_percent also sets how often in_valid is offered)
# Isolated words with the output always ready
iso_words single 20 1 100
iso_more single 12 11 100
# Both sides always on, so writes and reads collide often
collide stream 200 2 100
collide_b stream 120 12 100
# Random back-pressure on the output side
bp_30 stream 300 3 30
bp_70 stream 300 4 70
bp_50 stream 150 14 50
# Fill the SRAM and the output buffer, then drain
fill_full full 71 5 100
# Write with the output stalled, then read everything back
drain_mid drain 40 6 60
drain_small drain 3 7 100
drain_big drain 70 8 90
# Mixed traffic after the drains
mix_end stream 100 9 80

/* nobl_fifo_top.f */
+incdir+include
design/nobl_fifo_pkg.sv
design/nobl_fifo.sv
design/nobl_if.sv
design/nobl_read_pacer.sv
design/nobl_fifo_top.sv
verification/nobl_sram_model.sv
verification/nobl_fifo_chk.sv
verification/nobl_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the NoBL FIFO testbench with Verilator, run it and judge the result from the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary --timing --assert --top-module nobl_fifo_tb \
	-f nobl_fifo_top.f -Mdir obj_dir -o nobl_fifo_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/nobl_fifo_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation ended with an error status"
	exit 1
fi

cat sim.log
if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
